// ==== rtl/dlxPkg.sv ====
// widths, memory depth and register count
// opcode and ALU function encodings
// structs passed between the pipeline stages and to the top-level ports
package dlxPkg;

   localparam int dataW    = 32;
   localparam int instrW   = 32;
   localparam int regAddrW = 5;
   localparam int numRegs  = 32;
   localparam int memAddrW = 8;   // PC and data address, word addressed
   localparam int memSize  = 256;

   // instruction layout
   //   [31:26] opcode
   //   [25:21] rs1, base or first operand
   //   [20:16] rs2, also destination for ADDI and LW
   //   [15:11] rd for ALU operations
   //   [15:0]  imm16, absolute target for J
   //   [2:0]   ALU function when opcode is opAlu
   typedef enum logic [5:0] {
      opNop  = 6'd0,
      opAlu  = 6'd1,
      opAddi = 6'd2,
      opLw   = 6'd3,
      opSw   = 6'd4,
      opBeqz = 6'd5,
      opBnez = 6'd6,
      opJ    = 6'd7,
      opHalt = 6'd8
   } opcodeT;

   typedef enum logic [2:0] {
      fnAdd = 3'd0,
      fnSub = 3'd1,
      fnAnd = 3'd2,
      fnOr  = 3'd3,
      fnXor = 3'd4
   } aluFuncT;

   typedef struct packed {
      logic                valid;
      opcodeT              opcode;
      aluFuncT             func;
      logic [dataW-1:0]    a;
      logic [dataW-1:0]    b;
      logic [dataW-1:0]    imm;     // sign extended imm16
      logic [regAddrW-1:0] dest;    // 0 means no write
      logic [memAddrW-1:0] pc;
   } decExT;

   typedef struct packed {
      logic                valid;
      opcodeT              opcode;
      logic [dataW-1:0]    result;  // ALU value or memory address
      logic [dataW-1:0]    storeData;
      logic [regAddrW-1:0] dest;
   } exResT;

   typedef struct packed {
      logic                valid;
      logic [regAddrW-1:0] regAddr;
      logic [dataW-1:0]    data;
   } wbT;

   typedef struct packed {
      logic                valid;
      logic [memAddrW-1:0] addr;
      logic [dataW-1:0]    data;
   } memWrT;

endpackage

// ==== rtl/regFile.sv ====
// register file, 32 words, two read ports and one write port
// writes bypass to the reads in the same cycle, r0 stays zero
`timescale 1ns/1ps

module regFile (
   input  logic                        Clk,
   input  logic                        rstN,
   input  logic [dlxPkg::regAddrW-1:0] raddrA,
   input  logic [dlxPkg::regAddrW-1:0] raddrB,
   output logic [dlxPkg::dataW-1:0]    rdataA,
   output logic [dlxPkg::dataW-1:0]    rdataB,
   input  dlxPkg::wbT                  wr
);

   logic [dlxPkg::dataW-1:0] regs [dlxPkg::numRegs];
   logic                     wrHit;

   assign wrHit = wr.valid && (wr.regAddr != '0);   // r0 never written

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < dlxPkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrHit) begin
         regs[wr.regAddr] <= wr.data;
      end
   end

   // new value visible to a read in the write cycle
   assign rdataA = (wrHit && (wr.regAddr == raddrA)) ? wr.data : regs[raddrA];
   assign rdataB = (wrHit && (wr.regAddr == raddrB)) ? wr.data : regs[raddrB];

   // r0 reads zero on both ports
   r0ReadsZero : assert property (@(posedge Clk) disable iff (!rstN)
      ((raddrA != '0) || (rdataA == '0)) && ((raddrB != '0) || (rdataB == '0)));

endmodule

// ==== rtl/fetchUnit.sv ====
// program counter with incrementer, redirect and hold
// instruction memory, synchronous read, written through the load port
`timescale 1ns/1ps

module fetchUnit (
   input  logic                        Clk,
   input  logic                        rstN,
   input  logic                        run,
   input  logic                        hold,
   input  logic                        redirect,
   input  logic [dlxPkg::memAddrW-1:0] target,
   input  logic                        progWe,
   input  logic [dlxPkg::memAddrW-1:0] progAddr,
   input  logic [dlxPkg::instrW-1:0]   progData,
   output logic [dlxPkg::instrW-1:0]   instr,
   output logic [dlxPkg::memAddrW-1:0] instrPc,
   output logic                        fetched
);

   logic [dlxPkg::instrW-1:0]   imem [dlxPkg::memSize];
   logic [dlxPkg::memAddrW-1:0] pc;
   logic [dlxPkg::memAddrW-1:0] pcInc;

   assign pcInc = pc + 1'b1;   // word step

   // program load port
   always_ff @(posedge Clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         pc      <= '0;
         fetched <= 1'b0;
      end else if (!run) begin
         pc      <= '0;   // restart from 0 on next run
         fetched <= 1'b0;
      end else if (redirect) begin
         pc      <= target;   // wrong-path word is squashed in decode
         fetched <= 1'b1;
      end else if (hold) begin
         fetched <= 1'b0;
      end else begin
         pc      <= pcInc;
         fetched <= 1'b1;
      end
   end

   // instruction word and its address travel together
   always_ff @(posedge Clk) begin
      if (run) begin
         instr   <= imem[pc];
         instrPc <= pc;
      end
   end

   progWhileIdle : assert property (@(posedge Clk) disable iff (!rstN)
      run |-> !progWe);

endmodule

// ==== rtl/decodeStage.sv ====
// field split, sign extension and register read
// squash after redirect, halt detection and the hold latch
// decode-to-execute pipeline register
`timescale 1ns/1ps

module decodeStage (
   input  logic                        Clk,
   input  logic                        rstN,
   input  logic                        run,
   input  logic [dlxPkg::instrW-1:0]   instr,
   input  logic [dlxPkg::memAddrW-1:0] instrPc,
   input  logic                        fetched,
   input  logic                        redirect,
   input  dlxPkg::wbT                  wr,
   output logic                        hold,
   output dlxPkg::decExT               toEx
);

   dlxPkg::opcodeT                opcode;
   dlxPkg::aluFuncT               func;
   logic [dlxPkg::regAddrW-1:0]   rs1;
   logic [dlxPkg::regAddrW-1:0]   rs2;
   logic [dlxPkg::regAddrW-1:0]   rd;
   logic [dlxPkg::regAddrW-1:0]   dest;
   logic [dlxPkg::dataW-1:0]      imm;
   logic [dlxPkg::dataW-1:0]      rdA;
   logic [dlxPkg::dataW-1:0]      rdB;
   logic                          squashQ;
   logic                          slotLive;

   assign opcode = dlxPkg::opcodeT'(instr[31:26]);
   assign func   = dlxPkg::aluFuncT'(instr[2:0]);
   assign rs1    = instr[25:21];
   assign rs2    = instr[20:16];
   assign rd     = instr[15:11];
   assign imm    = {{(dlxPkg::dataW-16){instr[15]}}, instr[15:0]};

   regFile rf (
      .Clk    (Clk),
      .rstN   (rstN),
      .raddrA (rs1),
      .raddrB (rs2),
      .rdataA (rdA),
      .rdataB (rdB),
      .wr     (wr)
   );

   always_comb begin
      case (opcode)
         dlxPkg::opAlu:  dest = rd;
         dlxPkg::opAddi,
         dlxPkg::opLw:   dest = rs2;   // I-type destination
         default:        dest = '0;    // stores, branches, halt
      endcase
   end

   // the word held now dies under redirect, the next one via squashQ
   assign slotLive = fetched && !redirect && !squashQ && !hold;

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         squashQ <= 1'b0;
         hold    <= 1'b0;
      end else if (!run) begin
         squashQ <= 1'b0;
         hold    <= 1'b0;
      end else begin
         squashQ <= redirect;
         if (slotLive && (opcode == dlxPkg::opHalt)) begin
            hold <= 1'b1;   // freeze fetch until run falls
         end
      end
   end

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         toEx <= '0;
      end else begin
         toEx.valid  <= run && slotLive;
         toEx.opcode <= opcode;
         toEx.func   <= func;
         toEx.a      <= rdA;
         toEx.b      <= rdB;
         toEx.imm    <= imm;
         toEx.dest   <= dest;
         toEx.pc     <= instrPc;
      end
   end

endmodule

// ==== rtl/executeStage.sv ====
// ALU, address adder and zero test
// branch and jump resolution, execute-to-result register
`timescale 1ns/1ps

module executeStage (
   input  logic                        Clk,
   input  logic                        rstN,
   input  logic                        run,
   input  dlxPkg::decExT               fromDec,
   output logic                        redirect,
   output logic [dlxPkg::memAddrW-1:0] target,
   output dlxPkg::exResT               toRes
);

   logic [dlxPkg::dataW-1:0] aluOut;
   logic [dlxPkg::dataW-1:0] sum;
   logic [dlxPkg::dataW-1:0] result;
   logic                     aZero;
   logic                     taken;

   assign sum = fromDec.a + fromDec.imm;   // ADDI and load/store address

   always_comb begin
      case (fromDec.func)
         dlxPkg::fnAdd: aluOut = fromDec.a + fromDec.b;
         dlxPkg::fnSub: aluOut = fromDec.a - fromDec.b;
         dlxPkg::fnAnd: aluOut = fromDec.a & fromDec.b;
         dlxPkg::fnOr:  aluOut = fromDec.a | fromDec.b;
         dlxPkg::fnXor: aluOut = fromDec.a ^ fromDec.b;
         default:       aluOut = '0;
      endcase
   end

   assign result = (fromDec.opcode == dlxPkg::opAlu) ? aluOut : sum;

   assign aZero = (fromDec.a == '0);

   always_comb begin
      case (fromDec.opcode)
         dlxPkg::opBeqz: taken = aZero;
         dlxPkg::opBnez: taken = !aZero;
         dlxPkg::opJ:    taken = 1'b1;
         default:        taken = 1'b0;
      endcase
   end

   assign redirect = fromDec.valid && taken;

   // J is absolute, branches are relative to the next word
   assign target = (fromDec.opcode == dlxPkg::opJ) ?
                   fromDec.imm[dlxPkg::memAddrW-1:0] :
                   fromDec.pc + 1'b1 + fromDec.imm[dlxPkg::memAddrW-1:0];

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         toRes <= '0;
      end else begin
         toRes.valid     <= run && fromDec.valid;
         toRes.opcode    <= fromDec.opcode;
         toRes.result    <= result;
         toRes.storeData <= fromDec.b;
         toRes.dest      <= fromDec.dest;
      end
   end

   // taken only from a live slot, and both shadow slots arrive empty
   redirectShadow : assert property (@(posedge Clk) disable iff (!rstN)
      redirect |-> fromDec.valid ##1 !fromDec.valid [*2]);

endmodule

// ==== rtl/resultStage.sv ====
// data memory, asynchronous read and synchronous write
// load and store, register write-back and the halted flag
`timescale 1ns/1ps

module resultStage (
   input  logic          Clk,
   input  logic          rstN,
   input  logic          run,
   input  dlxPkg::exResT fromEx,
   output dlxPkg::wbT    wb,
   output dlxPkg::memWrT memWr,
   output logic          halted
);

   logic [dlxPkg::dataW-1:0]    dmem [dlxPkg::memSize];
   logic [dlxPkg::memAddrW-1:0] addr;
   logic                        live;
   logic                        writesReg;
   logic                        haltNow;
   logic                        haltedQ;

   assign addr = fromEx.result[dlxPkg::memAddrW-1:0];   // word index
   assign live = run && fromEx.valid;

   assign memWr.valid = live && (fromEx.opcode == dlxPkg::opSw);
   assign memWr.addr  = addr;
   assign memWr.data  = fromEx.storeData;

   always_ff @(posedge Clk) begin
      if (memWr.valid) begin
         dmem[memWr.addr] <= memWr.data;
      end
   end

   assign writesReg = (fromEx.opcode == dlxPkg::opAlu) ||
                      (fromEx.opcode == dlxPkg::opAddi) ||
                      (fromEx.opcode == dlxPkg::opLw);

   assign wb.valid   = live && writesReg && (fromEx.dest != '0);
   assign wb.regAddr = fromEx.dest;
   assign wb.data    = (fromEx.opcode == dlxPkg::opLw) ? dmem[addr] : fromEx.result;

   assign haltNow = live && (fromEx.opcode == dlxPkg::opHalt);

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         haltedQ <= 1'b0;
      end else if (!run) begin
         haltedQ <= 1'b0;
      end else if (haltNow) begin
         haltedQ <= 1'b1;
      end
   end

   assign halted = run && (haltedQ || haltNow);   // up as HALT arrives

   // sticky until run drops
   haltedSticky : assert property (@(posedge Clk) disable iff (!rstN)
      halted |=> halted || !run);

endmodule

// ==== rtl/dlxCore.sv ====
// top level of the three-stage core
// fetch/decode, execute and result stages with load, write-back and store ports
`timescale 1ns/1ps

module dlxCore (
   input  logic                        Clk,
   input  logic                        rstN,
   input  logic                        run,
   input  logic                        progWe,
   input  logic [dlxPkg::memAddrW-1:0] progAddr,
   input  logic [dlxPkg::instrW-1:0]   progData,
   output dlxPkg::wbT                  wb,
   output dlxPkg::memWrT               memWr,
   output logic                        halted
);

   logic [dlxPkg::instrW-1:0]   instr;
   logic [dlxPkg::memAddrW-1:0] instrPc;
   logic                        fetched;
   logic                        hold;
   logic                        redirect;
   logic [dlxPkg::memAddrW-1:0] target;
   dlxPkg::decExT               decToEx;
   dlxPkg::exResT               exToRes;

   fetchUnit fetch (
      .Clk      (Clk),
      .rstN     (rstN),
      .run      (run),
      .hold     (hold),
      .redirect (redirect),
      .target   (target),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .instr    (instr),
      .instrPc  (instrPc),
      .fetched  (fetched)
   );

   decodeStage decode (
      .Clk      (Clk),
      .rstN     (rstN),
      .run      (run),
      .instr    (instr),
      .instrPc  (instrPc),
      .fetched  (fetched),
      .redirect (redirect),
      .wr       (wb),        // write-back also feeds the register file
      .hold     (hold),
      .toEx     (decToEx)
   );

   executeStage execute (
      .Clk      (Clk),
      .rstN     (rstN),
      .run      (run),
      .fromDec  (decToEx),
      .redirect (redirect),
      .target   (target),
      .toRes    (exToRes)
   );

   resultStage result (
      .Clk    (Clk),
      .rstN   (rstN),
      .run    (run),
      .fromEx (exToRes),
      .wb     (wb),
      .memWr  (memWr),
      .halted (halted)
   );

endmodule

// ==== tb/clockGen.sv ====
// free-running testbench clock, 100 ns period
`timescale 1ns/1ps

module clockGen (
   output logic Clk
);

   initial begin
      Clk = 1'b0;
   end

   always #50 Clk = ~Clk;   // half period

endmodule

// ==== tb/dlxTb.sv ====
// directed tests for the three-stage DLX core
// instruction set reference model, LFSR stimulus, timeout and report
`timescale 1ns/1ps

module dlxTb;

   typedef struct packed {
      logic        isStore;
      logic [7:0]  where;   // register index or store address
      logic [31:0] data;
   } eventT;

   // six short programs of well under 300 load and run cycles each
   localparam int maxCycles = 3000;

   logic                        Clk;
   logic                        rstN;
   logic                        run;
   logic                        progWe;
   logic [dlxPkg::memAddrW-1:0] progAddr;
   logic [dlxPkg::instrW-1:0]   progData;
   dlxPkg::wbT                  wb;
   dlxPkg::memWrT               memWr;
   logic                        halted;

   logic [31:0] prog [256];
   logic [31:0] mRegs [32];   // model state kept across tests like the DUT
   logic [31:0] mMem [256];
   eventT       expQ [$];
   eventT       gotQ [$];
   int          gotCyc [$];
   int          progLen;
   int          haltCycle;
   int          errors;
   int          testErrStart;
   int          testsRun;
   int          testsFailed;
   int          cycleCount;
   logic [31:0] lfsrState;

   clockGen clkGen (
      .Clk (Clk)
   );

   dlxCore UUT (
      .Clk      (Clk),
      .rstN     (rstN),
      .run      (run),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .wb       (wb),
      .memWr    (memWr),
      .halted   (halted)
   );

   always @(posedge Clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= maxCycles) begin
         $display("run stopped after %0d cycles without finishing", cycleCount);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsrState = lfsrNext(lfsrState);
         v = {v[30:0], lfsrState[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] instrWord(input dlxPkg::opcodeT op, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [15:0] imm);
      return {op, rs1, rs2, imm};
   endfunction

   function automatic logic [31:0] aluWord(input dlxPkg::aluFuncT fn, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
      return instrWord(dlxPkg::opAlu, rs1, rs2, {rd, 8'h00, fn});
   endfunction

   function automatic void addWord(input logic [31:0] w);
      prog[progLen] = w;
      progLen++;
   endfunction

   function automatic string describe(input eventT e);
      if (e.isStore) begin
         return $sformatf("memWr addr=%0d data=%h", e.where, e.data);
      end
      return $sformatf("wb reg=%0d data=%h", e.where, e.data);
   endfunction

   function automatic void modelWrite(input logic [4:0] r, input logic [31:0] v);
      if (r != 0) begin   // r0 writes vanish
         mRegs[r] = v;
         expQ.push_back(eventT'({1'b0, 3'b000, r, v}));
      end
   endfunction

   task automatic failValue(input string sig, input string expS, input string gotS);
      $display("Fail t=%0t %s: expected %s, got %s", $time, sig, expS, gotS);
      errors++;
   endtask

   task automatic failNote(input string what);
      $display("Error at t=%0t: %s", $time, what);
      errors++;
   endtask

   // executes prog from word 0 and queues the expected events
   task automatic runModel();
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      logic [7:0]  pc;
      logic        done;
      int          steps;
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         w     = prog[pc];
         a     = mRegs[w[25:21]];
         b     = mRegs[w[20:16]];
         addr  = a + {{16{w[15]}}, w[15:0]};
         pc    = pc + 1'b1;
         steps++;
         case (w[31:26])
            dlxPkg::opAlu: begin
               case (w[2:0])
                  dlxPkg::fnAdd: modelWrite(w[15:11], a + b);
                  dlxPkg::fnSub: modelWrite(w[15:11], a - b);
                  dlxPkg::fnAnd: modelWrite(w[15:11], a & b);
                  dlxPkg::fnOr:  modelWrite(w[15:11], a | b);
                  dlxPkg::fnXor: modelWrite(w[15:11], a ^ b);
                  default: ;
               endcase
            end
            dlxPkg::opAddi: modelWrite(w[20:16], addr);
            dlxPkg::opLw:   modelWrite(w[20:16], mMem[addr[7:0]]);
            dlxPkg::opSw: begin
               mMem[addr[7:0]] = b;
               expQ.push_back(eventT'({1'b1, addr[7:0], b}));
            end
            dlxPkg::opBeqz: pc = (a == 0) ? pc + w[7:0] : pc;   // relative to next word
            dlxPkg::opBnez: pc = (a != 0) ? pc + w[7:0] : pc;
            dlxPkg::opJ:    pc = w[7:0];
            dlxPkg::opHalt: done = 1'b1;
            default: ;
         endcase
      end
      if (!done) begin
         failNote("reference model ran 1000 steps without reaching HALT");
      end
   endtask

   // load, run until halted, then compare against the model
   task automatic runProgram();
      int i;
      int cyc;
      expQ.delete();
      gotQ.delete();
      gotCyc.delete();
      for (i = 0; i < progLen; i++) begin
         @(posedge Clk);
         progWe   <= 1'b1;
         progAddr <= i[7:0];
         progData <= prog[i];
      end
      @(posedge Clk);
      progWe <= 1'b0;
      runModel();
      @(posedge Clk);
      run <= 1'b1;
      cyc       = -1;   // cycle 0 is before the first edge with run high
      haltCycle = -1;
      while (haltCycle < 0) begin
         @(negedge Clk);
         cyc++;
         if (wb.valid) begin
            gotQ.push_back(eventT'({1'b0, 3'b000, wb.regAddr, wb.data}));
            gotCyc.push_back(cyc);
         end
         if (memWr.valid) begin
            gotQ.push_back(eventT'({1'b1, memWr.addr, memWr.data}));
            gotCyc.push_back(cyc);
         end
         if (halted) begin
            haltCycle = cyc;
         end
      end
      @(negedge Clk);
      if (!halted || wb.valid || memWr.valid) begin
         failNote("halted dropped or an event followed HALT while run was high");
      end
      @(posedge Clk);
      run <= 1'b0;
      @(negedge Clk);
      if (halted) begin
         failNote("halted stayed high after run fell");
      end
      if (gotQ.size() != expQ.size()) begin
         failValue("number of wb and memWr events", $sformatf("%0d", expQ.size()),
                   $sformatf("%0d", gotQ.size()));
      end
      for (i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
         if (gotQ[i] !== expQ[i]) begin
            failValue($sformatf("wb/memWr event %0d", i), describe(expQ[i]),
                      describe(gotQ[i]));
         end
      end
   endtask

   task automatic startTest();
      testErrStart = errors;
      progLen      = 0;
   endtask

   task automatic finishTest(input string name);
      testsRun++;
      if (errors == testErrStart) begin
         $display("%-14s passed", name);
      end else begin
         testsFailed++;
         $display("%-14s failed with %0d errors", name, errors - testErrStart);
      end
   endtask

   task automatic testArith();
      startTest();
      addWord(instrWord(dlxPkg::opAddi, 0, 1, 16'h1234));
      addWord(32'h0);
      addWord(instrWord(dlxPkg::opAddi, 0, 2, 16'hfffb));   // r2 = -5
      addWord(32'h0);
      addWord(aluWord(dlxPkg::fnAdd, 3, 1, 2));
      addWord(aluWord(dlxPkg::fnSub, 4, 1, 2));
      addWord(aluWord(dlxPkg::fnAnd, 5, 1, 2));
      addWord(aluWord(dlxPkg::fnOr, 6, 1, 2));
      addWord(aluWord(dlxPkg::fnXor, 7, 1, 2));
      addWord(aluWord(dlxPkg::fnSub, 8, 3, 4));
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));
      runProgram();
      finishTest("arithmetic");
   endtask

   task automatic testLoadStore();
      startTest();
      addWord(instrWord(dlxPkg::opAddi, 0, 1, 16'h55aa));
      addWord(instrWord(dlxPkg::opAddi, 0, 2, 20));
      addWord(32'h0);
      addWord(instrWord(dlxPkg::opSw, 2, 1, 3));          // mem[23] = r1
      addWord(instrWord(dlxPkg::opSw, 2, 2, 16'hffff));   // mem[19] = r2
      addWord(instrWord(dlxPkg::opLw, 2, 10, 3));
      addWord(instrWord(dlxPkg::opLw, 0, 11, 19));
      addWord(32'h0);
      addWord(aluWord(dlxPkg::fnAdd, 12, 10, 11));
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));
      runProgram();
      finishTest("load/store");
   endtask

   task automatic testBranches();
      startTest();
      addWord(instrWord(dlxPkg::opAddi, 0, 1, 0));
      addWord(instrWord(dlxPkg::opAddi, 0, 2, 7));
      addWord(32'h0);
      addWord(instrWord(dlxPkg::opBeqz, 1, 0, 2));   // taken to word 6
      addWord(instrWord(dlxPkg::opAddi, 0, 3, 1));
      addWord(instrWord(dlxPkg::opAddi, 0, 3, 2));
      addWord(instrWord(dlxPkg::opBnez, 1, 0, 5));   // not taken
      addWord(instrWord(dlxPkg::opAddi, 0, 4, 3));
      addWord(instrWord(dlxPkg::opBeqz, 2, 0, 5));   // not taken
      addWord(instrWord(dlxPkg::opAddi, 0, 5, 4));
      addWord(instrWord(dlxPkg::opBnez, 2, 0, 2));   // taken to word 13
      addWord(instrWord(dlxPkg::opAddi, 0, 6, 5));
      addWord(instrWord(dlxPkg::opAddi, 0, 6, 6));
      addWord(instrWord(dlxPkg::opJ, 0, 0, 16));
      addWord(instrWord(dlxPkg::opAddi, 0, 7, 7));
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));   // HALT in the jump shadow
      addWord(instrWord(dlxPkg::opAddi, 0, 8, 8));
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));
      runProgram();
      finishTest("branches");
   endtask

   task automatic testRegZero();
      startTest();
      addWord(instrWord(dlxPkg::opAddi, 0, 0, 16'h0077));
      addWord(aluWord(dlxPkg::fnAdd, 0, 1, 2));
      addWord(32'h0);
      addWord(aluWord(dlxPkg::fnAdd, 13, 0, 0));
      addWord(instrWord(dlxPkg::opAddi, 0, 14, 9));
      addWord(instrWord(dlxPkg::opSw, 0, 0, 30));   // stores r0
      addWord(aluWord(dlxPkg::fnOr, 15, 0, 14));
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));
      runProgram();
      finishTest("register zero");
   endtask

   task automatic testRandom();
      int          i;
      logic [31:0] kind;
      logic [31:0] imm;
      logic [31:0] rd;
      logic [31:0] rs1;
      logic [31:0] rs2;
      startTest();
      for (i = 0; i < 40; i++) begin
         kind = randBits(3);
         rd   = randBits(3) + 1;   // r1 to r8
         rs1  = randBits(3);
         rs2  = randBits(3);
         imm  = randBits(16);
         if (kind < 5) begin
            addWord(aluWord(dlxPkg::aluFuncT'(kind[2:0]), rd[4:0], rs1[4:0], rs2[4:0]));
         end else begin
            addWord(instrWord(dlxPkg::opAddi, rs1[4:0], rd[4:0], imm[15:0]));
         end
         addWord(32'h0);   // result ready before the next op reads it
      end
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));
      runProgram();
      finishTest("random alu");
   endtask

   task automatic testLatencyHalt();
      startTest();
      addWord(instrWord(dlxPkg::opAddi, 0, 17, 16'h0abc));
      addWord(instrWord(dlxPkg::opHalt, 0, 0, 0));
      runProgram();
      if (gotCyc.size() == 0) begin
         failNote("no write-back appeared after run rose");
      end else begin
         if (gotCyc[0] != 3) begin
            failValue("first wb.valid cycle", "3", $sformatf("%0d", gotCyc[0]));
         end
         if (haltCycle <= gotCyc[gotCyc.size()-1]) begin
            failValue("halted rise cycle", $sformatf("after %0d", gotCyc[gotCyc.size()-1]),
                      $sformatf("%0d", haltCycle));
         end
      end
      finishTest("latency/halt");
   endtask

   initial begin
      int i;
      rstN         = 1'b0;
      run          = 1'b0;
      progWe       = 1'b0;
      progAddr     = '0;
      progData     = '0;
      lfsrState    = 32'h2ba3c2e1;
      errors       = 0;
      testErrStart = 0;
      testsRun     = 0;
      testsFailed  = 0;
      cycleCount   = 0;
      progLen      = 0;
      for (i = 0; i < 32; i++) begin
         mRegs[i] = '0;   // register file clears on reset
      end
      repeat (16) @(posedge Clk);
      rstN <= 1'b1;
      @(posedge Clk);
      testArith();
      testLoadStore();
      testBranches();
      testRegZero();
      testRandom();
      testLatencyHalt();
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               testsRun, testsRun - testsFailed, testsFailed, errors);
      if (testsFailed == 0 && errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
rtl/dlxPkg.sv
rtl/regFile.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/dlxCore.sv
tb/clockGen.sv
tb/dlxTb.sv
